//--- design/bankCtrl.sv
`timescale 1ns/10ps

`include "rscDec_cfg.svh"

module bankCtrl
  import rscDecPkg::*;
(
  input  logic  iclk,
  input  logic  reset,
  input  logic  closeBank,     // writer finished a block
  input  logic  releaseBank,   // reader finished a pass
  output bank_t writeBank,
  output bank_t readBank,
  output logic  anyEmpty,
  output logic  allEmpty,
  output logic  anyFull,
  output logic  allFull
);

  localparam int NBANK = 2 ** `RSC_BNUM_W;
  localparam int CNT_W = `RSC_BNUM_W + 1;

  typedef logic [CNT_W-1:0] cnt_t;

  localparam cnt_t CNT_FULL = cnt_t'(NBANK);
  localparam cnt_t CNT_LAST = cnt_t'(NBANK - 1);

  cnt_t fullCnt;   // number of banks holding a complete block

  // ------------------------------------------------
  // pointers and occupancy
  // ------------------------------------------------
  always_ff @(posedge iclk) begin
    if (reset) begin
      writeBank <= '0;
      readBank  <= '0;
      fullCnt   <= '0;
    end else begin
      if (closeBank)   writeBank <= writeBank + 1'b1;   // wraps over the banks
      if (releaseBank) readBank  <= readBank + 1'b1;
      case ({closeBank, releaseBank})
        2'b10:   fullCnt <= fullCnt + 1'b1;
        2'b01:   fullCnt <= fullCnt - 1'b1;
        default: fullCnt <= fullCnt;   // none, or one in and one out
      endcase
    end
  end

  // the closing cycle already counts as taken, so the writer cannot slip
  // a symbol into the next bank before the count catches up
  assign anyEmpty = (fullCnt != CNT_FULL) && !(closeBank && fullCnt == CNT_LAST);
  assign allEmpty = (fullCnt == '0);
  assign anyFull  = (fullCnt != '0);
  assign allFull  = (fullCnt == CNT_FULL);

  // writer must never close a bank the reader still owns
  closeNotFull : assert property (@(posedge iclk) disable iff (reset)
    closeBank |-> !allFull);
  // reader only releases a bank it was given
  releaseNotEmpty : assert property (@(posedge iclk) disable iff (reset)
    releaseBank |-> !allEmpty);

endmodule

//--- design/dualReadRam.sv
`timescale 1ns/10ps

`include "rscDec_cfg.svh"

module dualReadRam
  import rscDecPkg::*;
#(
  parameter int ADDR_W = `RSC_BNUM_W + `RSC_ADDR_W   // bank bits + local address
)(
  input  logic              iclk,
  input  logic              reset,
  input  logic              writeEn,
  input  logic [ADDR_W-1:0] writeAddr,
  input  llrPair_t          writeData,
  input  logic [ADDR_W-1:0] readAddr0,
  input  logic [ADDR_W-1:0] readAddr1,
  output llrPair_t          readData0,
  output llrPair_t          readData1
);

  llrPair_t          mem [2**ADDR_W];
  logic [ADDR_W-1:0] rdAddr0, rdAddr1;   // address seen by the array
  llrPair_t          ramOut0, ramOut1;   // array output register

  always_ff @(posedge iclk) begin
    if (writeEn) mem[writeAddr] <= writeData;
  end

  // ------------------------------------------------
  // optional address stage
  // ------------------------------------------------
  if (`RSC_APIPE != 0) begin : gAddrReg
    always_ff @(posedge iclk) begin
      if (reset) begin
        rdAddr0 <= '0;
        rdAddr1 <= '0;
      end else begin
        rdAddr0 <= readAddr0;
        rdAddr1 <= readAddr1;
      end
    end
  end else begin : gAddrDirect
    assign rdAddr0 = readAddr0;
    assign rdAddr1 = readAddr1;
  end

  always_ff @(posedge iclk) begin
    ramOut0 <= mem[rdAddr0];   // synchronous read, two ports
    ramOut1 <= mem[rdAddr1];
  end

  // ------------------------------------------------
  // optional data stage
  // ------------------------------------------------
  if (`RSC_DPIPE != 0) begin : gDataReg
    always_ff @(posedge iclk) begin
      if (reset) begin
        readData0 <= '0;
        readData1 <= '0;
      end else begin
        readData0 <= ramOut0;
        readData1 <= ramOut1;
      end
    end
  end else begin : gDataDirect
    assign readData0 = ramOut0;
    assign readData1 = ramOut1;
  end

endmodule

//--- design/inputBuffer.sv
`timescale 1ns/10ps

`include "rscDec_cfg.svh"

module inputBuffer
  import rscDecPkg::*;
(
  input  logic       iclk,
  input  logic       reset,
  // write side
  input  logic       writeEn,
  input  logic [1:0] writeSel,    // [0] y, [1] w, both also s
  input  addr_t      writeAddr,
  input  llrPair_t   sLlr,
  input  llrPair_t   yLlr,
  input  llrPair_t   wLlr,
  input  logic       closeBank,
  input  tag_t       closeTag,
  // read side
  input  addr_t      fwdAddr,
  input  addr_t      bwdAddr,
  input  logic       releaseBank,
  output llrPair_t   fsLlr,
  output llrPair_t   fyLlr,
  output llrPair_t   fwLlr,
  output llrPair_t   bsLlr,
  output llrPair_t   byLlr,
  output llrPair_t   bwLlr,
  output tag_t       bankTag,
  // status
  output logic       anyEmpty,
  output logic       allEmpty,
  output logic       anyFull,
  output logic       allFull
);

  localparam int RAM_ADDR_W = `RSC_BNUM_W + `RSC_ADDR_W;

  bank_t writeBank, readBank;
  logic  sWe, yWe, wWe;
  logic [RAM_ADDR_W-1:0] wrAddr, fwdRamAddr, bwdRamAddr;
  tag_t  tagMem [2**`RSC_BNUM_W];   // one tag per bank

  bankCtrl u_bankCtrl (
    .iclk        (iclk),
    .reset       (reset),
    .closeBank   (closeBank),
    .releaseBank (releaseBank),
    .writeBank   (writeBank),
    .readBank    (readBank),
    .anyEmpty    (anyEmpty),
    .allEmpty    (allEmpty),
    .anyFull     (anyFull),
    .allFull     (allFull)
  );

  // ------------------------------------------------
  // address build and write decode
  // ------------------------------------------------
  assign wrAddr     = {writeBank, writeAddr};
  assign fwdRamAddr = {readBank, fwdAddr};   // bank fixed at issue time
  assign bwdRamAddr = {readBank, bwdAddr};

  assign sWe = writeEn & (&writeSel);   // s only on full symbols
  assign yWe = writeEn & writeSel[0];
  assign wWe = writeEn & writeSel[1];

  dualReadRam #(.ADDR_W(RAM_ADDR_W)) sRam (
    .iclk (iclk), .reset (reset),
    .writeEn (sWe), .writeAddr (wrAddr), .writeData (sLlr),
    .readAddr0 (fwdRamAddr), .readAddr1 (bwdRamAddr),
    .readData0 (fsLlr), .readData1 (bsLlr)
  );

  dualReadRam #(.ADDR_W(RAM_ADDR_W)) yRam (
    .iclk (iclk), .reset (reset),
    .writeEn (yWe), .writeAddr (wrAddr), .writeData (yLlr),
    .readAddr0 (fwdRamAddr), .readAddr1 (bwdRamAddr),
    .readData0 (fyLlr), .readData1 (byLlr)
  );

  dualReadRam #(.ADDR_W(RAM_ADDR_W)) wRam (
    .iclk (iclk), .reset (reset),
    .writeEn (wWe), .writeAddr (wrAddr), .writeData (wLlr),
    .readAddr0 (fwdRamAddr), .readAddr1 (bwdRamAddr),
    .readData0 (fwLlr), .readData1 (bwLlr)
  );

  // tag goes with the bank being closed
  always_ff @(posedge iclk) begin
    if (closeBank) tagMem[writeBank] <= closeTag;
  end

  assign bankTag = tagMem[readBank];

endmodule

//--- design/llrWriter.sv
`timescale 1ns/10ps

`include "rscDec_cfg.svh"

module llrWriter
  import rscDecPkg::*;
(
  input  logic       iclk,
  input  logic       reset,
  input  logic       symValid,
  input  logic [1:0] symSel,
  input  rawPair_t   sRaw,
  input  rawPair_t   yRaw,
  input  rawPair_t   wRaw,
  input  tag_t       blockTag,
  input  logic       inReady,
  output logic       writeEn,
  output logic [1:0] writeSel,
  output addr_t      writeAddr,
  output llrPair_t   sLlr,
  output llrPair_t   yLlr,
  output llrPair_t   wLlr,
  output logic       closeBank,
  output tag_t       closeTag
);

  localparam int    LLR_MAX   = 2 ** (`RSC_LLR_W - 1) - 1;   // symmetric clamp
  localparam addr_t LAST_ADDR = addr_t'(`RSC_BLOCK_LEN - 1);

  logic  accept;
  addr_t addrCnt;

  // clamp to +-LLR_MAX then keep the low bits, no scaling
  function automatic llr_t saturate(raw_t x);
    if (x > LLR_MAX)  return llr_t'(LLR_MAX);
    if (x < -LLR_MAX) return llr_t'(-LLR_MAX);
    return llr_t'(x[`RSC_LLR_W-1:0]);
  endfunction

  assign accept = symValid & inReady;

  // ------------------------------------------------
  // control: address count and bank close
  // ------------------------------------------------
  always_ff @(posedge iclk) begin
    if (reset) begin
      addrCnt   <= '0;
      writeEn   <= 1'b0;
      closeBank <= 1'b0;
    end else begin
      writeEn   <= accept;
      closeBank <= accept && (addrCnt == LAST_ADDR);   // last symbol of block
      if (accept) addrCnt <= (addrCnt == LAST_ADDR) ? '0 : addrCnt + 1'b1;
    end
  end

  // payload, one cycle behind the accepted symbol
  always_ff @(posedge iclk) begin
    writeSel  <= symSel;
    writeAddr <= addrCnt;
    closeTag  <= blockTag;
    for (int i = 0; i < 2; i++) begin
      sLlr[i] <= saturate(sRaw[i]);
      yLlr[i] <= saturate(yRaw[i]);
      wLlr[i] <= saturate(wRaw[i]);
    end
  end

  // a stalled symbol stays on the inputs until it is taken
  symHeldWhileStalled : assert property (@(posedge iclk) disable iff (reset)
    symValid && !inReady |=> symValid && $stable({symSel, sRaw, yRaw, wRaw, blockTag}));

endmodule

//--- design/readSequencer.sv
`timescale 1ns/10ps

`include "rscDec_cfg.svh"

module readSequencer
  import rscDecPkg::*;
(
  input  logic  iclk,
  input  logic  reset,
  input  logic  anyFull,
  input  tag_t  bankTag,
  output addr_t fwdAddr,
  output addr_t bwdAddr,
  output logic  releaseBank,
  output logic  outValid,
  output logic  outLast,
  output tag_t  outTag
);

  localparam int    RD_LAT    = 1 + `RSC_APIPE + `RSC_DPIPE;   // ram read latency
  localparam addr_t LAST_ADDR = addr_t'(`RSC_BLOCK_LEN - 1);

  logic  issue;             // an address pair goes out this cycle
  addr_t passCnt;
  tag_t  passTag, tagIn;
  logic  [RD_LAT-1:0] validPipe, lastPipe;
  tag_t  tagPipe [RD_LAT];

  // a full bank stays full for its whole pass, so this is the run flag
  assign issue       = anyFull;
  assign fwdAddr     = passCnt;
  assign bwdAddr     = LAST_ADDR - passCnt;   // mirror of forward
  assign releaseBank = issue && (passCnt == LAST_ADDR);
  assign tagIn       = (passCnt == '0) ? bankTag : passTag;

  // ------------------------------------------------
  // pass counter
  // ------------------------------------------------
  always_ff @(posedge iclk) begin
    if (reset) begin
      passCnt <= '0;
    end else if (issue) begin
      passCnt <= releaseBank ? '0 : passCnt + 1'b1;
    end
  end

  always_ff @(posedge iclk) begin
    if (issue && passCnt == '0) passTag <= bankTag;   // latch at pass start
  end

  // ------------------------------------------------
  // flags ride along with the ram latency
  // ------------------------------------------------
  always_ff @(posedge iclk) begin
    if (reset) begin
      validPipe <= '0;
      lastPipe  <= '0;
    end else begin
      validPipe[0] <= issue;
      lastPipe[0]  <= releaseBank;
      for (int i = 1; i < RD_LAT; i++) begin
        validPipe[i] <= validPipe[i-1];
        lastPipe[i]  <= lastPipe[i-1];
      end
    end
  end

  always_ff @(posedge iclk) begin
    tagPipe[0] <= tagIn;   // keeps old tag for the tail of a back-to-back pass
    for (int i = 1; i < RD_LAT; i++) tagPipe[i] <= tagPipe[i-1];
  end

  assign outValid = validPipe[RD_LAT-1];
  assign outLast  = lastPipe[RD_LAT-1];
  assign outTag   = tagPipe[RD_LAT-1];

endmodule

//--- design/rscDecInput.sv
`timescale 1ns/10ps

module rscDecInput
  import rscDecPkg::*;
(
  input  logic       iclk,
  input  logic       reset,
  // symbol input
  input  logic       symValid,
  input  logic [1:0] symSel,
  input  rawPair_t   sRaw,
  input  rawPair_t   yRaw,
  input  rawPair_t   wRaw,
  input  tag_t       blockTag,
  output logic       inReady,
  // forward / backward llr output
  output llrPair_t   fsLlr,
  output llrPair_t   fyLlr,
  output llrPair_t   fwLlr,
  output llrPair_t   bsLlr,
  output llrPair_t   byLlr,
  output llrPair_t   bwLlr,
  output logic       outValid,
  output logic       outLast,
  output tag_t       outTag,
  // buffer status
  output logic       allEmpty,
  output logic       anyFull,
  output logic       allFull
);

  logic       writeEn, closeBank, releaseBank;
  logic [1:0] writeSel;
  addr_t      writeAddr, fwdAddr, bwdAddr;
  llrPair_t   sLlr, yLlr, wLlr;
  tag_t       closeTag, bankTag;

  // ------------------------------------------------
  // writer -> buffer -> sequencer
  // ------------------------------------------------
  llrWriter u_llrWriter (
    .iclk (iclk), .reset (reset),
    .symValid (symValid), .symSel (symSel),
    .sRaw (sRaw), .yRaw (yRaw), .wRaw (wRaw),
    .blockTag (blockTag), .inReady (inReady),   // free bank doubles as ready
    .writeEn (writeEn), .writeSel (writeSel), .writeAddr (writeAddr),
    .sLlr (sLlr), .yLlr (yLlr), .wLlr (wLlr),
    .closeBank (closeBank), .closeTag (closeTag)
  );

  inputBuffer u_inputBuffer (
    .iclk (iclk), .reset (reset),
    .writeEn (writeEn), .writeSel (writeSel), .writeAddr (writeAddr),
    .sLlr (sLlr), .yLlr (yLlr), .wLlr (wLlr),
    .closeBank (closeBank), .closeTag (closeTag),
    .fwdAddr (fwdAddr), .bwdAddr (bwdAddr), .releaseBank (releaseBank),
    .fsLlr (fsLlr), .fyLlr (fyLlr), .fwLlr (fwLlr),
    .bsLlr (bsLlr), .byLlr (byLlr), .bwLlr (bwLlr),
    .bankTag (bankTag),
    .anyEmpty (inReady), .allEmpty (allEmpty),
    .anyFull (anyFull), .allFull (allFull)
  );

  readSequencer u_readSequencer (
    .iclk (iclk), .reset (reset),
    .anyFull (anyFull), .bankTag (bankTag),
    .fwdAddr (fwdAddr), .bwdAddr (bwdAddr), .releaseBank (releaseBank),
    .outValid (outValid), .outLast (outLast), .outTag (outTag)
  );

endmodule

//--- design/rscDecPkg.sv
package rscDecPkg;

  `include "rscDec_cfg.svh"

  // llr of one bit and the duobit pair
  typedef logic signed [`RSC_LLR_W-1:0] llr_t;
  typedef llr_t        [1:0]             llrPair_t;   // [0] first bit, [1] second bit

  // raw samples as they come off the channel
  typedef logic signed [`RSC_RAW_W-1:0] raw_t;
  typedef raw_t        [1:0]             rawPair_t;

  typedef logic [`RSC_ADDR_W-1:0] addr_t;   // bank-local address
  typedef logic [`RSC_BNUM_W-1:0] bank_t;
  typedef logic [`RSC_TAG_W-1:0]  tag_t;

endpackage

//--- include/rscDec_cfg.svh
`ifndef RSCDEC_CFG_SVH
`define RSCDEC_CFG_SVH

// ------------------------------------------------
// sample and llr widths
// ------------------------------------------------
`define RSC_RAW_W      7    // raw channel sample, signed
`define RSC_LLR_W      5    // quantized llr, signed

// ------------------------------------------------
// buffer geometry
// ------------------------------------------------
`define RSC_ADDR_W     5    // symbol address inside one bank
`define RSC_BNUM_W     1    // bank index bits, 2 banks
`define RSC_TAG_W      8
`define RSC_BLOCK_LEN  20   // symbols per block, <= 2**RSC_ADDR_W

`define RSC_APIPE      1    // ram read address register
`define RSC_DPIPE      0    // ram read data register

`endif

//--- rscDecInput.f
+incdir+include
design/rscDecPkg.sv
design/bankCtrl.sv
design/dualReadRam.sv
design/inputBuffer.sv
design/llrWriter.sv
design/readSequencer.sv
design/rscDecInput.sv
testbench/rscDecInputTb.sv

//--- run.sh
#!/bin/bash
# compile and run the rscDecInput testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module rscDecInputTb \
  -f rscDecInput.f > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/VrscDecInputTb > sim.log 2>&1

grep -q "Verification failed" sim.log && { echo "FAIL, see sim.log"; exit 1; }
grep -q "Verification passed" sim.log && echo "PASS" || { echo "no result in sim.log"; exit 1; }

//--- testbench/rscDecInputTb.sv
`timescale 1ns/10ps

`include "rscDec_cfg.svh"

module rscDecInputTb
  import rscDecPkg::*;
();

  localparam int BLK     = `RSC_BLOCK_LEN;
  localparam int NBANK   = 1 << `RSC_BNUM_W;
  localparam int LLR_MAX = (1 << (`RSC_LLR_W - 1)) - 1;   // symmetric llr range
  localparam int NSMP    = 64;                             // sample table capacity

  logic       iclk;
  logic       reset;
  logic       symValid;
  logic [1:0] symSel;
  rawPair_t   sRaw, yRaw, wRaw;
  tag_t       blockTag, outTag;
  logic       inReady, outValid, outLast, allEmpty, anyFull, allFull;
  llrPair_t   fsLlr, fyLlr, fwLlr, bsLlr, byLlr, bwLlr;

  int               seed = 51;
  int               smp [NSMP][6];   // s0 s1 y0 y1 w0 w1
  int               numSmp, numBlk;
  tag_t             blkTag [$];
  logic [2*BLK-1:0] blkSel [$];      // 2 bits per symbol, symbol 0 lowest
  int               blkOff [$];
  bit               loaded;
  int               stallCnt, passCnt, outIdx;
  int               fullRef;         // full banks in the model
  int               passPos;         // pairs issued in the model pass
  bit               closeMark;       // last symbol of a block just taken
  bit               closeRef;        // closeBank expected this cycle

  llrPair_t refS [NBANK][BLK];   // what each bank holds now
  llrPair_t refY [NBANK][BLK];
  llrPair_t refW [NBANK][BLK];
  llrPair_t expS [$];            // closed blocks in read order
  llrPair_t expY [$];
  llrPair_t expW [$];
  tag_t     expTag [$];
  llrPair_t curS [BLK];          // block under read
  llrPair_t curY [BLK];
  llrPair_t curW [BLK];
  tag_t     curTag;

  rscDecInput u_rscDecInput (
    .iclk (iclk), .reset (reset),
    .symValid (symValid), .symSel (symSel),
    .sRaw (sRaw), .yRaw (yRaw), .wRaw (wRaw),
    .blockTag (blockTag), .inReady (inReady),
    .fsLlr (fsLlr), .fyLlr (fyLlr), .fwLlr (fwLlr),
    .bsLlr (bsLlr), .byLlr (byLlr), .bwLlr (bwLlr),
    .outValid (outValid), .outLast (outLast), .outTag (outTag),
    .allEmpty (allEmpty), .anyFull (anyFull), .allFull (allFull)
  );

  initial iclk = 1'b0;
  always #10 iclk = ~iclk;   // 20 ns period

  // --------------------------------------------------
  // error exit and compare tasks
  // --------------------------------------------------
  task automatic abortRun(string why);
    $display("%s", why);
    $display("Verification failed");
    $fatal(1, "run stopped on the error above");
  endtask

  task automatic checkLlrPair(string name, llrPair_t exp, llrPair_t act);
    if (act !== exp)
      abortRun($sformatf("mismatch %s: expected %0d %0d, actual %0d %0d",
                         name, exp[0], exp[1], act[0], act[1]));
  endtask

  task automatic checkTag(string name, tag_t exp, tag_t act);
    if (act !== exp)
      abortRun($sformatf("mismatch %s: expected %h, actual %h", name, exp, act));
  endtask

  task automatic checkFlag(string name, bit exp, bit act);
    if (act !== exp)
      abortRun($sformatf("mismatch %s: expected %0d, actual %0d", name, exp, act));
  endtask

  // clamp into +-LLR_MAX, no scaling
  function automatic llr_t clampRaw(int v);
    if (v > LLR_MAX) return llr_t'(LLR_MAX);
    if (v < -LLR_MAX) return llr_t'(-LLR_MAX);
    return llr_t'(v);
  endfunction

  function automatic llrPair_t makePair(int a, int b);
    llrPair_t p;
    p[0] = clampRaw(a);
    p[1] = clampRaw(b);
    return p;
  endfunction

  // --------------------------------------------------
  // testdata file
  // --------------------------------------------------
  task automatic readTestdata();
    int               fd, n, off;
    int               v0, v1, v2, v3, v4, v5;
    string            line, kind;
    tag_t             t;
    logic [2*BLK-1:0] sel;
    numSmp = 0;
    fd = $fopen("testbench/rscDecInput_testdata.txt", "r");
    if (fd == 0) abortRun("cannot open testbench/rscDecInput_testdata.txt");
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 0 && $sscanf(line, "%s", kind) == 1) begin
        if (kind == "smp") begin
          n = $sscanf(line, "%s %d %d %d %d %d %d", kind, v0, v1, v2, v3, v4, v5);
          if (n != 7 || numSmp >= NSMP) abortRun($sformatf("bad sample line: %s", line));
          smp[numSmp][0] = v0;
          smp[numSmp][1] = v1;
          smp[numSmp][2] = v2;
          smp[numSmp][3] = v3;
          smp[numSmp][4] = v4;
          smp[numSmp][5] = v5;
          numSmp++;
        end else if (kind == "blk") begin
          n = $sscanf(line, "%s %h %h %d", kind, t, sel, off);
          if (n != 4) abortRun($sformatf("bad block line: %s", line));
          blkTag.push_back(t);
          blkSel.push_back(sel);
          blkOff.push_back(off);
        end else if (kind[0] != "#") begin
          abortRun($sformatf("unknown line in testdata: %s", line));
        end
      end
    end
    $fclose(fd);
    numBlk = blkTag.size();
    if (numBlk == 0 || numSmp == 0) abortRun("testdata holds no blocks or no samples");
  endtask

  // --------------------------------------------------
  // writer side
  // --------------------------------------------------
  task automatic sendBlock(int b, bit useGaps);
    int               idx, gap;
    bit               taken;
    bank_t            bank;
    logic [1:0]       sel;
    logic [2*BLK-1:0] selWord;
    bank    = bank_t'(b % NBANK);   // banks fill in turn
    selWord = blkSel[b];
    for (int k = 0; k < BLK; k++) begin
      gap = useGaps ? ($random(seed) & 3) : 0;
      if (gap > 0) begin
        repeat (gap) @(posedge iclk);
        #2;
      end
      idx      = (blkOff[b] + k) % numSmp;
      sel      = selWord[2*k +: 2];
      symValid = 1'b1;
      symSel   = sel;
      blockTag = blkTag[b];
      sRaw[0]  = raw_t'(smp[idx][0]);
      sRaw[1]  = raw_t'(smp[idx][1]);
      yRaw[0]  = raw_t'(smp[idx][2]);
      yRaw[1]  = raw_t'(smp[idx][3]);
      wRaw[0]  = raw_t'(smp[idx][4]);
      wRaw[1]  = raw_t'(smp[idx][5]);
      taken    = 1'b0;
      while (!taken) begin
        @(negedge iclk);
        taken = inReady;
        if (!taken) stallCnt++;   // held and offered again
        @(posedge iclk);
        #2;
      end
      symValid = 1'b0;
      if (k == BLK - 1) closeMark = 1'b1;   // closeBank follows this edge
      if (sel == 2'b11) refS[bank][k] = makePair(smp[idx][0], smp[idx][1]);
      if (sel[0]) refY[bank][k] = makePair(smp[idx][2], smp[idx][3]);
      if (sel[1]) refW[bank][k] = makePair(smp[idx][4], smp[idx][5]);
    end
    // snapshot of the closed bank, old contents kept where sel skipped
    for (int a = 0; a < BLK; a++) begin
      expS.push_back(refS[bank][a]);
      expY.push_back(refY[bank][a]);
      expW.push_back(refW[bank][a]);
    end
    expTag.push_back(blkTag[b]);
  endtask

  // --------------------------------------------------
  // bank occupancy model, one step per cycle
  // --------------------------------------------------
  task automatic stepBankModel();
    bit rel;
    rel = (fullRef > 0) && (passPos == BLK - 1);   // last pair of a pass
    if (fullRef > 0) passPos = rel ? 0 : passPos + 1;
    fullRef   = fullRef + closeRef - rel;
    closeRef  = closeMark;
    closeMark = 1'b0;
  endtask

  task automatic checkBankFlags();
    checkFlag("allEmpty", fullRef == 0, allEmpty);
    checkFlag("anyFull", fullRef > 0, anyFull);
    checkFlag("allFull", fullRef == NBANK, allFull);
    // the bank being closed is not free for the next symbol yet
    checkFlag("inReady", fullRef + closeRef < NBANK, inReady);
  endtask

  // --------------------------------------------------
  // read side monitor
  // --------------------------------------------------
  task automatic checkOutput();
    string id;
    int    r;
    if (outIdx == 0 && expTag.size() == 0) begin
      abortRun("outValid with no closed block waiting");
    end else begin
      if (outIdx == 0) begin
        curTag = expTag.pop_front();
        for (int a = 0; a < BLK; a++) begin
          curS[a] = expS.pop_front();
          curY[a] = expY.pop_front();
          curW[a] = expW.pop_front();
        end
      end
      r  = BLK - 1 - outIdx;   // backward sweep
      id = $sformatf("pass %0d k %0d", passCnt, outIdx);
      checkLlrPair({id, " fwd s"}, curS[outIdx], fsLlr);
      checkLlrPair({id, " fwd y"}, curY[outIdx], fyLlr);
      checkLlrPair({id, " fwd w"}, curW[outIdx], fwLlr);
      checkLlrPair({id, " bwd s"}, curS[r], bsLlr);
      checkLlrPair({id, " bwd y"}, curY[r], byLlr);
      checkLlrPair({id, " bwd w"}, curW[r], bwLlr);
      checkTag({id, " tag"}, curTag, outTag);
      checkFlag({id, " last"}, outIdx == BLK - 1, outLast);
      if (outIdx == BLK - 1) begin
        outIdx = 0;
        passCnt++;
      end else begin
        outIdx++;
      end
    end
  endtask

  always @(negedge iclk) begin
    if (loaded && !reset) begin
      stepBankModel();
      checkBankFlags();
      if (outValid) checkOutput();
      else if (outIdx != 0) abortRun("outValid dropped inside a pass");
    end
  end

  initial begin
    wait (loaded);
    repeat (numBlk * (2 * BLK + 20) + 200) @(posedge iclk);
    abortRun($sformatf("timeout with %0d of %0d passes read", passCnt, numBlk));
  end

  initial begin
    symValid  = 1'b0;
    symSel    = 2'b00;
    sRaw      = '0;
    yRaw      = '0;
    wRaw      = '0;
    blockTag  = '0;
    reset     = 1'b1;
    loaded    = 1'b0;
    stallCnt  = 0;
    passCnt   = 0;
    outIdx    = 0;
    fullRef   = 0;
    passPos   = 0;
    closeMark = 1'b0;
    closeRef  = 1'b0;
    readTestdata();
    loaded = 1'b1;
    repeat (16) @(posedge iclk);
    #2;
    reset = 1'b0;
    @(negedge iclk);
    checkFlag("allEmpty after reset", 1'b1, allEmpty);
    checkFlag("inReady after reset", 1'b1, inReady);
    checkFlag("anyFull after reset", 1'b0, anyFull);
    checkFlag("outValid after reset", 1'b0, outValid);
    @(posedge iclk);
    #2;
    for (int b = 0; b < numBlk; b++) begin
      sendBlock(b, b < numBlk / 2);   // back half at full rate so the writer stalls
    end
    wait (passCnt == numBlk);
    repeat (4) @(negedge iclk);   // nothing may follow the last pass
    checkFlag("allEmpty at end", 1'b1, allEmpty);
    checkFlag("back-pressure seen", 1'b1, stallCnt > 0);
    checkFlag("all closed blocks read", 1'b1, expTag.size() == 0);
    $display("Verification passed");
    $finish;
  end

endmodule

//--- testbench/rscDecInput_testdata.txt
# smp s0 s1 y0 y1 w0 w1 : raw samples, signed decimal, 7 bit range
# blk tag sel offset : tag hex, symSel hex 2 bits per symbol (symbol 0 lowest), first smp row
smp 0 1 -1 2 -2 3
smp 15 -15 16 -16 63 -64
smp 7 -8 14 -14 30 -30
smp -64 63 0 5 -5 12
smp 20 -20 11 -11 9 -9
smp 4 -4 40 -40 15 -15
smp -16 16 -3 3 25 -25
smp 13 -13 50 -50 1 -1
smp 6 -7 -33 33 -12 12
smp 10 -10 2 -2 60 -60
smp -1 0 17 -17 8 -8
smp 31 -31 -6 6 14 -14
smp 3 -2 -64 63 -15 15
smp 12 -12 9 -9 22 -22
smp -9 9 35 -35 -4 4
smp 5 5 -5 -5 0 0
smp 45 -45 13 -13 -7 7
smp -11 11 1 -1 18 -18
smp 8 -8 -26 26 11 -11
smp 2 -3 28 -28 -10 10
blk a5 ffffffffff 0
blk 3c ffffffffff 7
blk 5a 56a9f56a9f 13
blk c3 a5f0a5f0a5 5
blk 0f ffffffffff 11
blk e1 9696969696 3
